// File: hw/ebox_cfg.svh
`ifndef EBOX_CFG_SVH
`define EBOX_CFG_SVH

// ======================================================================
// Word and address widths of the execution box
// ======================================================================

// data word, bit 0 is the most significant.
`define EBOX_WORD 36

// fast memory holds sixteen accumulators.
`define EBOX_AC_COUNT 16
`define EBOX_AC_BITS 4

// micro-address width, giving a sixteen word control store.
`define EBOX_UADR_BITS 4

// the dispatch word that every instruction starts from.
`define EBOX_UADR_ENTRY 0

`endif

// File: hw/eboxPkg.sv
package eboxPkg;

  // ======================================================================
  // Instruction opcodes, taken from bits 0..3 of the instruction word
  // ======================================================================
  typedef enum logic [3:0] {
    opMove = 4'd0, // AC gets E.
    opAdd  = 4'd1,
    opSub  = 4'd2,
    opAnd  = 4'd3,
    opIor  = 4'd4,
    opXor  = 4'd5  // codes above this one are illegal.
  } tInstOp;

  // ======================================================================
  // Micro-operations held in the control store
  // ======================================================================
  typedef enum logic [1:0] {
    uNop      = 2'd0,
    uReadAc   = 2'd1, // BR gets the addressed accumulator.
    uLoadAr   = 2'd2, // AR gets E.
    uAluWrite = 2'd3  // AD result goes back to the accumulator.
  } tMicroOp;

  // sequencer states.
  typedef enum logic [1:0] {
    sIdle = 2'd0,
    sRun  = 2'd1,
    sDone = 2'd2
  } tCraState;

endpackage

// File: hw/ir.sv
`timescale 1ns/1ps
`include "ebox_cfg.svh"

module ir(
  input  logic                     eboxClk,
  input  logic                     rstN,
  input  logic                     loadIr,
  input  logic [0:`EBOX_WORD-1]    inst,
  output eboxPkg::tInstOp          irOp,
  output logic [0:`EBOX_AC_BITS-1] irAc,
  output logic [0:`EBOX_WORD-1]    irE,
  output logic                     irIllegal
);

  logic opLegal;

  always_comb begin
    case (eboxPkg::tInstOp'(inst[0:3]))
      eboxPkg::opMove, eboxPkg::opAdd, eboxPkg::opSub,
      eboxPkg::opAnd, eboxPkg::opIor, eboxPkg::opXor: opLegal = 1'b1;
      default: opLegal = 1'b0;
    endcase
  end

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      irIllegal <= 1'b0;
    end else if (loadIr) begin
      irIllegal <= !opLegal; // the only place where the opcode range is checked.
    end
  end

  always_ff @(posedge eboxClk) begin
    if (loadIr) begin
      irOp <= eboxPkg::tInstOp'(inst[0:3]);
      irAc <= inst[9:12];
      irE  <= {{(`EBOX_WORD-18){1'b0}}, inst[18:`EBOX_WORD-1]}; // E is zero-extended.
    end
  end

endmodule

// File: hw/cra.sv
`timescale 1ns/1ps
`include "ebox_cfg.svh"

module cra(
  input  logic                       eboxClk,
  input  logic                       rstN,
  input  logic                       instStrobe,
  input  logic [0:`EBOX_UADR_BITS-1] uNext,
  input  eboxPkg::tMicroOp           uOp,
  output logic [0:`EBOX_UADR_BITS-1] uAdr,
  output logic                       loadIr,
  output logic                       busy
);

  eboxPkg::tCraState state;

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      state  <= eboxPkg::sIdle;
      uAdr   <= `EBOX_UADR_BITS'(`EBOX_UADR_ENTRY);
      loadIr <= 1'b0;
      busy   <= 1'b0;
    end else begin
      loadIr <= 1'b0;
      case (state)
        eboxPkg::sIdle, eboxPkg::sDone: begin
          state <= eboxPkg::sIdle;
          if (instStrobe) begin
            loadIr <= 1'b1; // ir takes the word on the next edge.
            state  <= eboxPkg::sRun;
            uAdr   <= `EBOX_UADR_BITS'(`EBOX_UADR_ENTRY);
          end
        end
        eboxPkg::sRun: begin
          uAdr <= uNext;
          busy <= 1'b1;
          if (uOp == eboxPkg::uAluWrite) begin
            busy  <= 1'b0; // the last step, a new strobe can follow.
            state <= eboxPkg::sDone;
          end
        end
        default: begin
          state <= eboxPkg::sIdle;
          busy  <= 1'b0;
        end
      endcase
    end
  end

  // dispatch, read, load and write leave busy high for three cycles.
  assert property (@(posedge eboxClk) disable iff (!rstN) $rose(busy) |-> ##3 !busy)
    else $error("busy held past the end of the micro-sequence");

endmodule

// File: hw/crm.sv
`timescale 1ns/1ps
`include "ebox_cfg.svh"

module crm(
  input  logic [0:`EBOX_UADR_BITS-1] uAdr,
  output eboxPkg::tMicroOp           uOp,
  output logic [0:`EBOX_UADR_BITS-1] uNext
);

  // ======================================================================
  // Control store layout
  // ======================================================================
  localparam logic [0:`EBOX_UADR_BITS-1] uaDispatch =
    `EBOX_UADR_BITS'(`EBOX_UADR_ENTRY);
  localparam logic [0:`EBOX_UADR_BITS-1] uaReadAc   = uaDispatch + 1'b1;
  localparam logic [0:`EBOX_UADR_BITS-1] uaLoadAr   = uaReadAc + 1'b1;
  localparam logic [0:`EBOX_UADR_BITS-1] uaAluWrite = uaLoadAr + 1'b1;

  always_comb begin
    uOp   = eboxPkg::uNop;
    uNext = uaDispatch; // unused words fall back to the entry.
    case (uAdr)
      uaDispatch: begin
        uOp   = eboxPkg::uNop; // ir is loading during this word.
        uNext = uaReadAc;
      end
      uaReadAc: begin
        uOp   = eboxPkg::uReadAc;
        uNext = uaLoadAr;
      end
      uaLoadAr: begin
        uOp   = eboxPkg::uLoadAr;
        uNext = uaAluWrite;
      end
      uaAluWrite: begin
        uOp   = eboxPkg::uAluWrite;
        uNext = uaDispatch;
      end
      default: begin
        uOp   = eboxPkg::uNop;
        uNext = uaDispatch;
      end
    endcase
  end

endmodule

// File: hw/edp.sv
`timescale 1ns/1ps
`include "ebox_cfg.svh"

module edp(
  input  logic                     eboxClk,
  input  logic                     rstN,
  input  eboxPkg::tMicroOp         uOp,
  input  eboxPkg::tInstOp          irOp,
  input  logic [0:`EBOX_AC_BITS-1] irAc,
  input  logic [0:`EBOX_WORD-1]    irE,
  input  logic                     irIllegal,
  input  logic [0:`EBOX_WORD-1]    fmReadData,
  output logic [0:`EBOX_AC_BITS-1] fmAdr,
  output logic                     fmWrite,
  output logic [0:`EBOX_WORD-1]    fmWriteData,
  output logic                     done,
  output logic                     resultZero,
  output logic                     carry0,
  output logic                     setOverflow,
  output logic                     setIllegal
);

  logic [0:`EBOX_WORD-1] ar;
  logic [0:`EBOX_WORD-1] br;
  logic [0:`EBOX_WORD-1] ad;
  logic                  adCarry;
  logic                  adOverflow;
  logic                  aluStep;

  // ======================================================================
  // AR and BR
  // ======================================================================
  always_ff @(posedge eboxClk) begin
    if (uOp == eboxPkg::uReadAc) br <= fmReadData;
    if (uOp == eboxPkg::uLoadAr) ar <= irE;
  end

  // ======================================================================
  // AD adder and logic unit
  // ======================================================================
  always_comb begin
    ad         = '0;
    adCarry    = 1'b0;
    adOverflow = 1'b0;
    case (irOp)
      eboxPkg::opMove: ad = ar;
      eboxPkg::opAdd: begin
        {adCarry, ad} = {1'b0, br} + {1'b0, ar};
        adOverflow    = (br[0] == ar[0]) && (ad[0] != br[0]);
      end
      eboxPkg::opSub: begin
        {adCarry, ad} = {1'b0, br} + {1'b0, ~ar} + 1'b1; // BR plus twos complement of AR.
        adOverflow    = (br[0] != ar[0]) && (ad[0] != br[0]);
      end
      eboxPkg::opAnd: ad = br & ar;
      eboxPkg::opIor: ad = br | ar;
      eboxPkg::opXor: ad = br ^ ar;
      default: ad = '0;
    endcase
  end

  assign aluStep     = (uOp == eboxPkg::uAluWrite);
  assign fmAdr       = irAc;
  assign fmWrite     = aluStep && !irIllegal; // illegal opcodes leave the AC alone.
  assign fmWriteData = ad;
  assign setOverflow = aluStep && !irIllegal && adOverflow;
  assign setIllegal  = aluStep && irIllegal;

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      done       <= 1'b0;
      resultZero <= 1'b0;
      carry0     <= 1'b0;
    end else begin
      done <= aluStep;
      if (aluStep) begin
        resultZero <= !irIllegal && (ad == '0);
        carry0     <= !irIllegal && adCarry;
      end
    end
  end

  // the write step must be followed by a done pulse of exactly one cycle.
  assert property (@(posedge eboxClk) disable iff (!rstN) fmWrite |=> done ##1 !done)
    else $error("accumulator write not followed by a single done pulse");

endmodule

// File: hw/fm.sv
`timescale 1ns/1ps
`include "ebox_cfg.svh"

module fm(
  input  logic                     eboxClk,
  input  logic                     rstN,
  input  logic [0:`EBOX_AC_BITS-1] fmAdr,
  input  logic                     fmWrite,
  input  logic [0:`EBOX_WORD-1]    fmWriteData,
  output logic [0:`EBOX_WORD-1]    fmReadData,
  input  logic                     busy,
  input  logic                     diagWrite,
  input  logic [0:`EBOX_AC_BITS-1] diagAdr,
  input  logic [0:`EBOX_WORD-1]    diagData,
  output logic [0:`EBOX_WORD-1]    diagReadData
);

  logic [0:`EBOX_WORD-1] acs [0:`EBOX_AC_COUNT-1];

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      for (int i = 0; i < `EBOX_AC_COUNT; i++) begin
        acs[i] <= '0; // accumulators come up cleared.
      end
    end else if (fmWrite) begin
      acs[fmAdr] <= fmWriteData;
    end else if (diagWrite && !busy) begin
      acs[diagAdr] <= diagData;
    end
  end

  assign fmReadData = acs[fmAdr];

  always_ff @(posedge eboxClk) begin
    diagReadData <= acs[diagAdr]; // old contents, as of this edge.
  end

endmodule

// File: hw/apr.sv
`timescale 1ns/1ps

module apr(
  input  logic eboxClk,
  input  logic rstN,
  input  logic setOverflow,
  input  logic setIllegal,
  input  logic diagClearFlags,
  output logic overflowFlag,
  output logic illegalFlag,
  output logic anyEboxError
);

  // ======================================================================
  // Sticky status flags
  // ======================================================================
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      overflowFlag <= 1'b0;
      illegalFlag  <= 1'b0;
    end else begin
      // a set on the same edge as a clear wins.
      overflowFlag <= setOverflow || (overflowFlag && !diagClearFlags);
      illegalFlag  <= setIllegal || (illegalFlag && !diagClearFlags);
    end
  end

  assign anyEboxError = overflowFlag || illegalFlag;

endmodule

// File: hw/ebox.sv
`timescale 1ns/1ps
`include "ebox_cfg.svh"

module ebox(
  input  logic                     eboxClk,
  input  logic                     rstN,
  input  logic                     instStrobe,
  input  logic [0:`EBOX_WORD-1]    inst,
  input  logic                     diagWrite,
  input  logic [0:`EBOX_AC_BITS-1] diagAdr,
  input  logic [0:`EBOX_WORD-1]    diagData,
  input  logic                     diagClearFlags,
  output logic                     busy,
  output logic                     done,
  output logic                     resultZero,
  output logic                     carry0,
  output logic [0:`EBOX_WORD-1]    diagReadData,
  output logic                     overflowFlag,
  output logic                     illegalFlag,
  output logic                     anyEboxError
);

  // ======================================================================
  // Internal nets
  // ======================================================================
  logic                       loadIr;
  eboxPkg::tInstOp            irOp;
  logic [0:`EBOX_AC_BITS-1]   irAc;
  logic [0:`EBOX_WORD-1]      irE;
  logic                       irIllegal;
  logic [0:`EBOX_UADR_BITS-1] uAdr;
  logic [0:`EBOX_UADR_BITS-1] uNext;
  eboxPkg::tMicroOp           uOp;
  logic [0:`EBOX_AC_BITS-1]   fmAdr;
  logic                       fmWrite;
  logic [0:`EBOX_WORD-1]      fmWriteData;
  logic [0:`EBOX_WORD-1]      fmReadData;
  logic                       setOverflow;
  logic                       setIllegal;

  ir ir0(.eboxClk, .rstN, .loadIr, .inst, .irOp, .irAc, .irE, .irIllegal);

  cra cra0(.eboxClk, .rstN, .instStrobe, .uNext, .uOp, .uAdr, .loadIr, .busy);

  crm crm0(.uAdr, .uOp, .uNext);

  edp edp0(.eboxClk, .rstN, .uOp, .irOp, .irAc, .irE, .irIllegal, .fmReadData,
           .fmAdr, .fmWrite, .fmWriteData, .done, .resultZero, .carry0,
           .setOverflow, .setIllegal);

  fm fm0(.eboxClk, .rstN, .fmAdr, .fmWrite, .fmWriteData, .fmReadData, .busy,
         .diagWrite, .diagAdr, .diagData, .diagReadData);

  apr apr0(.eboxClk, .rstN, .setOverflow, .setIllegal, .diagClearFlags,
           .overflowFlag, .illegalFlag, .anyEboxError);

endmodule

// File: sim/eboxMon.sv
`timescale 1ns/1ps
`include "ebox_cfg.svh"

module eboxMon(
  input  logic                     eboxClk,
  input  logic                     rstN,
  input  logic                     instStrobe,
  input  logic [0:`EBOX_WORD-1]    inst,
  input  logic                     diagWrite,
  input  logic [0:`EBOX_AC_BITS-1] diagAdr,
  input  logic [0:`EBOX_WORD-1]    diagData,
  input  logic                     diagClearFlags,
  input  logic                     busy,
  input  logic                     done,
  input  logic                     resultZero,
  input  logic                     carry0,
  input  logic [0:`EBOX_WORD-1]    diagReadData,
  input  logic                     overflowFlag,
  input  logic                     illegalFlag,
  input  logic                     anyEboxError,
  output int                       errorCount
);

  // ======================================================================
  // Reference model state
  // ======================================================================
  logic [`EBOX_WORD-1:0] acs [0:`EBOX_AC_COUNT-1];
  int                    phase; // 0 idle, 1 dispatch, 2 read, 3 load, 4 write.
  logic [3:0]            curOp;
  logic [3:0]            curAc;
  logic [`EBOX_WORD-1:0] curE;
  logic [`EBOX_WORD-1:0] brVal;
  logic [`EBOX_WORD-1:0] res;
  logic [`EBOX_WORD:0]   wide;
  logic [`EBOX_WORD:0]   signedWide;
  logic                  cy;
  logic                  ovf;
  logic                  busyBefore;
  logic                  setO;
  logic                  setI;
  logic                  exBusy;
  logic                  exDone;
  logic                  exZero;
  logic                  exCarry;
  logic                  exOvf;
  logic                  exIll;
  logic [`EBOX_WORD-1:0] exDiag;
  logic                  diagValid;
  logic                  armed;

  initial begin
    errorCount = 0;
    armed      = 1'b0;
    phase      = 0;
  end

  // works out the result of one instruction from the opcode rules.
  task automatic computeResult();
    cy  = 1'b0;
    ovf = 1'b0;
    res = '0;
    case (curOp)
      eboxPkg::opMove: res = curE;
      eboxPkg::opAdd: begin
        wide       = {1'b0, brVal} + {1'b0, curE};
        signedWide = {brVal[`EBOX_WORD-1], brVal} + {curE[`EBOX_WORD-1], curE};
        res        = wide[`EBOX_WORD-1:0];
        cy         = wide[`EBOX_WORD];
        ovf        = signedWide[`EBOX_WORD] != signedWide[`EBOX_WORD-1];
      end
      eboxPkg::opSub: begin
        signedWide = {brVal[`EBOX_WORD-1], brVal} - {curE[`EBOX_WORD-1], curE};
        res        = brVal - curE;
        cy         = (brVal >= curE); // no borrow means a carry out.
        ovf        = signedWide[`EBOX_WORD] != signedWide[`EBOX_WORD-1];
      end
      eboxPkg::opAnd: res = brVal & curE;
      eboxPkg::opIor: res = brVal | curE;
      eboxPkg::opXor: res = brVal ^ curE;
      default: res = '0;
    endcase
  endtask

  always @(posedge eboxClk) begin
    armed = 1'b1;
    if (!rstN) begin
      for (int i = 0; i < `EBOX_AC_COUNT; i++) begin
        acs[i] = '0;
      end
      phase = 0;
      {exBusy, exDone, exZero, exCarry, exOvf, exIll} = '0;
      diagValid = 1'b0;
    end else begin
      busyBefore = (phase >= 2);
      exDiag     = acs[diagAdr]; // read port shows the contents before this edge.
      diagValid  = 1'b1;
      setO       = 1'b0;
      setI       = 1'b0;
      exDone     = 1'b0;
      case (phase)
        0: begin
          if (instStrobe) begin
            curOp = inst[0:3];
            curAc = inst[9:12];
            curE  = {{(`EBOX_WORD-18){1'b0}}, inst[18:`EBOX_WORD-1]};
            phase = 1;
          end
        end
        1: phase = 2;
        2: begin
          brVal = acs[curAc];
          phase = 3;
        end
        3: phase = 4;
        default: begin
          computeResult();
          if (curOp <= 4'd5) begin
            acs[curAc] = res;
            exZero     = (res == '0);
            exCarry    = cy;
            setO       = ovf;
          end else begin
            exZero  = 1'b0;
            exCarry = 1'b0;
            setI    = 1'b1;
          end
          exDone = 1'b1;
          phase  = 0;
        end
      endcase
      if (diagWrite && !busyBefore) begin
        acs[diagAdr] = diagData;
      end
      exOvf  = setO || (exOvf && !diagClearFlags);
      exIll  = setI || (exIll && !diagClearFlags);
      exBusy = (phase >= 2);
    end
  end

  // ======================================================================
  // Output comparisons on the falling clock edge
  // ======================================================================
  task automatic compareValue(input string what, input logic [`EBOX_WORD-1:0] got,
                              input logic [`EBOX_WORD-1:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s is %h, model has %h", $time, what, got, exp);
    end
  endtask

  always @(negedge eboxClk) begin
    if (armed) begin
      compareValue("busy", busy, exBusy);
      compareValue("done", done, exDone);
      compareValue("resultZero", resultZero, exZero);
      compareValue("carry0", carry0, exCarry);
      compareValue("overflowFlag", overflowFlag, exOvf);
      compareValue("illegalFlag", illegalFlag, exIll);
      compareValue("anyEboxError", anyEboxError, exOvf || exIll);
      if (diagValid) begin
        compareValue("diagReadData", diagReadData, exDiag);
      end
    end
  end

endmodule

// File: sim/eboxTb.sv
`timescale 1ns/1ps
`include "ebox_cfg.svh"

module eboxTb;

  logic                     eboxClk;
  logic                     rstN;
  logic                     instStrobe;
  logic [0:`EBOX_WORD-1]    inst;
  logic                     diagWrite;
  logic [0:`EBOX_AC_BITS-1] diagAdr;
  logic [0:`EBOX_WORD-1]    diagData;
  logic                     diagClearFlags;
  logic                     busy;
  logic                     done;
  logic                     resultZero;
  logic                     carry0;
  logic [0:`EBOX_WORD-1]    diagReadData;
  logic                     overflowFlag;
  logic                     illegalFlag;
  logic                     anyEboxError;
  int                       checkErrors;
  int                       timeouts;
  logic [31:0]              lfsr;
  logic [35:0]              r;
  logic [3:0]               op;

  ebox ebox_inst(.eboxClk, .rstN, .instStrobe, .inst, .diagWrite, .diagAdr, .diagData,
                 .diagClearFlags, .busy, .done, .resultZero, .carry0, .diagReadData,
                 .overflowFlag, .illegalFlag, .anyEboxError);

  eboxMon mon(.eboxClk, .rstN, .instStrobe, .inst, .diagWrite, .diagAdr, .diagData,
              .diagClearFlags, .busy, .done, .resultZero, .carry0, .diagReadData,
              .overflowFlag, .illegalFlag, .anyEboxError, .errorCount(checkErrors));

  always #5 eboxClk = !eboxClk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1); // Galois form that shifts right.
  endfunction

  task automatic takeBits(input int n, output logic [35:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v    = {v[34:0], lfsr[0]};
    end
  endtask

  task automatic waitIdle();
    int count;
    count = 0;
    while (busy && count < 20) begin
      @(posedge eboxClk);
      count++;
    end
    if (busy) begin
      timeouts++;
      $display("timed out waiting for busy to fall at %0t", $time);
    end
  endtask

  task automatic writeAc(input logic [3:0] adr, input logic [35:0] data);
    waitIdle();
    @(posedge eboxClk);
    diagWrite <= 1'b1;
    diagAdr   <= adr;
    diagData  <= data;
    @(posedge eboxClk);
    diagWrite <= 1'b0;
  endtask

  task automatic pulseClear();
    @(posedge eboxClk);
    diagClearFlags <= 1'b1;
    @(posedge eboxClk);
    diagClearFlags <= 1'b0;
  endtask

  // runs one instruction and can add a strobe and a diag write while busy.
  task automatic runInst(input logic [3:0] opc, input logic [3:0] ac,
                         input logic [17:0] e, input logic pokeBusy);
    logic [35:0] fill;
    int          count;
    logic        seen;
    takeBits(10, fill);
    @(posedge eboxClk);
    instStrobe <= 1'b1;
    inst       <= {opc, fill[9:5], ac, fill[4:0], e}; // unused fields get noise.
    @(posedge eboxClk);
    instStrobe <= 1'b0;
    if (pokeBusy) begin
      takeBits(36, fill);
      @(posedge eboxClk);
      instStrobe <= 1'b1;
      inst       <= fill;
      diagWrite  <= 1'b1;
      diagAdr    <= ac;
      diagData   <= ~fill;
      @(posedge eboxClk);
      instStrobe <= 1'b0;
      diagWrite  <= 1'b0;
    end
    seen  = 1'b0;
    count = 0;
    while (!seen && count < 12) begin
      @(posedge eboxClk);
      seen = done;
      count++;
    end
    if (!seen) begin
      timeouts++;
      $display("timed out waiting for done at %0t", $time);
    end
  endtask

  initial begin
    #100000;
    $display("the simulation ran past its time limit");
    $display("Errors found");
    $finish;
  end

  initial begin
    eboxClk        = 1'b0;
    rstN           = 1'b0;
    instStrobe     = 1'b0;
    inst           = '0;
    diagWrite      = 1'b0;
    diagAdr        = '0;
    diagData       = '0;
    diagClearFlags = 1'b0;
    timeouts       = 0;
    lfsr           = 32'h9ca8ced4;
    repeat (4) @(posedge eboxClk);
    rstN <= 1'b1;

    // ======================================================================
    // Diagnostic port reset contents and random write readback
    // ======================================================================
    for (int a = 0; a < `EBOX_AC_COUNT; a++) begin
      @(posedge eboxClk);
      diagAdr <= a[3:0];
    end
    for (int k = 0; k < 24; k++) begin
      takeBits(4, r);
      op = r[3:0];
      takeBits(36, r);
      writeAc(op, r);
      @(posedge eboxClk);
      diagAdr <= op;
    end

    // ======================================================================
    // Random legal instructions with pokes while busy
    // ======================================================================
    for (int k = 0; k < 60; k++) begin
      takeBits(3, r);
      op = 4'(r % 6);
      takeBits(23, r);
      runInst(op, r[22:19], r[17:0], r[18]);
    end

    // ======================================================================
    // Carry, overflow, illegal opcodes and flag clearing
    // ======================================================================
    writeAc(4'd5, 36'hFFFFFFFFF);
    runInst(4'(eboxPkg::opAdd), 4'd5, 18'd1, 1'b0); // wraps to zero with a carry out.
    writeAc(4'd3, 36'h7FFFFFFFF);
    runInst(4'(eboxPkg::opAdd), 4'd3, 18'd1, 1'b0);
    pulseClear();
    writeAc(4'd4, 36'h800000000);
    runInst(4'(eboxPkg::opSub), 4'd4, 18'd5, 1'b0);
    pulseClear();
    for (int k = 0; k < 8; k++) begin
      takeBits(4, r);
      op = 4'(6 + (r % 10));
      takeBits(23, r);
      runInst(op, r[22:19], r[17:0], r[18]);
    end
    pulseClear();
    for (int a = 0; a < `EBOX_AC_COUNT; a++) begin
      @(posedge eboxClk);
      diagAdr <= a[3:0];
    end
    repeat (3) @(posedge eboxClk);

    $display("check errors: %0d, timeouts: %0d", checkErrors, timeouts);
    if (checkErrors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+hw
hw/eboxPkg.sv
hw/ir.sv
hw/cra.sv
hw/crm.sv
hw/edp.sv
hw/fm.sv
hw/apr.sv
hw/ebox.sv
sim/eboxMon.sv
sim/eboxTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module eboxTb -f tb.f
out=$(./obj_dir/VeboxTb)
echo "$out"
if echo "$out" | grep -qx "No errors"; then
  exit 0
else
  exit 1
fi
